// ==== rtl/mmu_pkg.sv ====
package mmu_pkg;

    // --------------------------------------------------
    // Page geometry
    // --------------------------------------------------
    localparam int PAGE_BITS       = 10;                 // Page index width
    localparam int PAGES           = 1 << PAGE_BITS;     // Entries per page table
    localparam int OFFSET_BITS     = 10;                 // Word offset inside a page
    localparam int BESM6_PAGE_BITS = 5;                  // Page bits seen in emulation mode

    typedef logic [PAGE_BITS-1:0]             page_num_t; // Virtual or physical page
    typedef logic [PAGE_BITS+OFFSET_BITS-1:0] vaddr_t;    // {page, offset}
    typedef logic [PAGE_BITS+OFFSET_BITS-1:0] physad_t;   // {frame, offset}
    typedef logic [3:0]                       bus_op_t;   // Bus opcode of a request

    // Used/dirty pair kept per physical page
    typedef logic [1:0] page_access_t;
    localparam int ACC_USED  = 0;                        // Page has been referenced
    localparam int ACC_DIRTY = 1;                        // Page has been modified

    // --------------------------------------------------
    // Write-class bus opcodes
    // --------------------------------------------------
    localparam bus_op_t OP_CCWR  = 4'd2;                 // Command cache write
    localparam bus_op_t OP_DCWR  = 4'd4;                 // Data cache write
    localparam bus_op_t OP_DWR   = 4'd10;                // Result write
    localparam bus_op_t OP_RDMWR = 4'd11;                // Read-modify-write
    localparam bus_op_t OP_BTRWR = 4'd12;                // Block transfer write

    // True when the opcode modifies memory, so the page gets dirty
    function automatic logic is_write_op(input bus_op_t op);
        logic wr;
        case (op)
            OP_CCWR,
            OP_DCWR,
            OP_DWR,
            OP_RDMWR,
            OP_BTRWR: wr = 1'b1;
            default:  wr = 1'b0;                         // Reads and fetches
        endcase
        return wr;
    endfunction

endpackage

// ==== rtl/page_ram.sv ====
`timescale 1ns/1ps

module page_ram
    import mmu_pkg::*;
#(
    parameter type entry_t = logic                  // Payload stored for each page
) (
    input  logic      clk,
    input  logic      i_wr_en,                      // Write strobe
    input  page_num_t i_wr_page,                    // Write index
    input  entry_t    i_wr_data,                    // Write payload
    input  page_num_t i_rd_page,                    // Read index, sampled every edge
    output entry_t    o_rd_data                     // Registered read data
);

    // --------------------------------------------------
    // Storage
    // --------------------------------------------------
    entry_t mem [PAGES];                            // One entry per page

    // Single write port
    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            mem[i_wr_page] <= i_wr_data;
        end
    end

    // Registered read port
    // A write on the same edge is not visible yet, old data comes out
    always_ff @(posedge clk) begin
        o_rd_data <= mem[i_rd_page];
    end

endmodule

// ==== rtl/credit_counter.sv ====
`timescale 1ns/1ps

module credit_counter #(
    parameter int CREDITS = 4                       // Responses allowed unreturned downstream
) (
    input  logic clk,
    input  logic reset,
    input  logic i_take,                            // Request accepted, one credit spent
    input  logic i_return,                          // Downstream hands one credit back
    output logic o_avail                            // At least one credit left
);

    localparam int CNT_BITS = $clog2(CREDITS + 1);  // Wide enough to hold CREDITS itself

    logic [CNT_BITS-1:0] credit_cnt;                // Credits still available
    logic [CNT_BITS-1:0] credit_nxt;

    // --------------------------------------------------
    // Next count
    // --------------------------------------------------
    always_comb begin
        case ({i_take, i_return})
            2'b10:   credit_nxt = credit_cnt - 1'b1; // Take only
            2'b01:   credit_nxt = credit_cnt + 1'b1; // Return only
            default: credit_nxt = credit_cnt;        // Both or neither
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            credit_cnt <= CNT_BITS'(CREDITS);       // Full pool after reset
        end else begin
            credit_cnt <= credit_nxt;
        end
    end

    // Readiness comes straight from the register
    assign o_avail = (credit_cnt != '0);

endmodule

// ==== rtl/reprio_fill_fsm.sv ====
`timescale 1ns/1ps

module reprio_fill_fsm
    import mmu_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      i_fill_start,                 // Start filling with ones, from page 0
    input  logic      i_wr,                         // External single-page write
    input  page_num_t i_wr_page,
    input  logic      i_wr_reprio,
    input  page_num_t i_rd_page,                    // External read index
    output logic      o_rd_reprio,                  // Read data, one cycle later
    output logic      o_busy                        // Fill in progress
);

    typedef enum logic {
        S_IDLE,                                     // External writes pass through
        S_FILL                                      // One page set per cycle
    } fill_state_t;

    fill_state_t state;
    page_num_t   fill_page;                         // Page written in the current fill cycle

    logic        ram_wr_en;
    page_num_t   ram_wr_page;
    logic        ram_wr_data;

    // --------------------------------------------------
    // Fill FSM and page counter
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= S_IDLE;
            fill_page <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (i_fill_start) begin
                        state     <= S_FILL;
                        fill_page <= '0;            // Fill always starts at page 0
                    end
                end
                S_FILL: begin
                    if (fill_page == page_num_t'(PAGES - 1)) begin
                        state <= S_IDLE;            // Last page written on this edge
                    end
                    fill_page <= fill_page + 1'b1;  // Wraps back to 0 at the end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Write mux, the fill owns the port while it runs
    always_comb begin
        if (state == S_FILL) begin
            ram_wr_en   = 1'b1;
            ram_wr_page = fill_page;
            ram_wr_data = 1'b1;
        end else begin
            ram_wr_en   = i_wr;
            ram_wr_page = i_wr_page;
            ram_wr_data = i_wr_reprio;
        end
    end

    assign o_busy = (state == S_FILL);

    page_ram #(
        .entry_t   (logic)
    ) u_reprio_ram (
        .clk       (clk),
        .i_wr_en   (ram_wr_en),
        .i_wr_page (ram_wr_page),
        .i_wr_data (ram_wr_data),
        .i_rd_page (i_rd_page),
        .o_rd_data (o_rd_reprio)
    );

endmodule

// ==== rtl/page_translate.sv ====
`timescale 1ns/1ps

module page_translate
    import mmu_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      i_accept,                     // Request taken on this edge
    input  vaddr_t    i_vaddr,
    input  bus_op_t   i_op,
    input  logic      i_mode_besm6,                 // Only five page bits count
    input  logic      i_no_paging,                  // Physical page = virtual page
    input  logic      i_map_wr,                     // Map entry write
    input  page_num_t i_map_vpage,
    input  page_num_t i_map_frame,
    input  logic      i_flag_wr,                    // External used/dirty write
    input  page_num_t i_flag_page,
    input  logic      i_flag_used,
    input  logic      i_flag_dirty,
    input  page_num_t i_flag_rd_page,               // External flag read index
    output logic      o_flag_used,
    output logic      o_flag_dirty,
    output logic      o_rsp_valid,
    output physad_t   o_rsp_physad,
    output bus_op_t   o_rsp_op
);

    page_num_t req_vpage;                           // Page index of the incoming request
    page_num_t map_frame;                           // Registered map output

    // Stage 1 registers
    logic                   s1_valid;
    page_num_t              s1_vpage;
    logic [OFFSET_BITS-1:0] s1_offset;
    bus_op_t                s1_op;
    logic                   s1_bypass;              // No-paging at acceptance time
    page_num_t              s1_page;                // Translated page

    // Stage 2 registers
    logic                   s2_valid;
    page_num_t              s2_page;
    logic [OFFSET_BITS-1:0] s2_offset;
    bus_op_t                s2_op;

    // Flag memory ports
    page_num_t              flag_rd_page;
    page_access_t           flag_rd_data;
    logic                   flag_wr_en;
    page_num_t              flag_wr_page;
    page_access_t           flag_wr_data;
    page_access_t           old_flags;              // Flags of s2_page before the update
    page_access_t           upd_flags;

    // Last flag write, covers a read that raced it on the same edge
    logic                   fwd_en;
    page_num_t              fwd_page;
    page_access_t           fwd_data;

    // --------------------------------------------------
    // Stage 1: virtual page, map read
    // --------------------------------------------------
    always_comb begin
        if (i_mode_besm6) begin
            req_vpage = page_num_t'(i_vaddr[OFFSET_BITS +: BESM6_PAGE_BITS]); // Zero-extended
        end else begin
            req_vpage = i_vaddr[OFFSET_BITS +: PAGE_BITS];
        end
    end

    page_ram #(
        .entry_t   (page_num_t)
    ) u_map_ram (
        .clk       (clk),
        .i_wr_en   (i_map_wr),
        .i_wr_page (i_map_vpage),
        .i_wr_data (i_map_frame),
        .i_rd_page (req_vpage),                     // Same-edge map write is not seen
        .o_rd_data (map_frame)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= i_accept;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_accept) begin
            s1_vpage  <= req_vpage;
            s1_offset <= i_vaddr[OFFSET_BITS-1:0];
            s1_op     <= i_op;
            s1_bypass <= i_no_paging;
        end
        if (s1_valid) begin
            s2_page   <= s1_page;
            s2_offset <= s1_offset;
            s2_op     <= s1_op;
        end
    end

    assign s1_page      = s1_bypass ? s1_vpage : map_frame;
    assign flag_rd_page = s1_valid ? s1_page : i_flag_rd_page; // Pipeline has priority

    // --------------------------------------------------
    // Stage 2: used/dirty update, response
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            fwd_en <= 1'b0;
        end else begin
            fwd_en <= flag_wr_en;
        end
        fwd_page <= flag_wr_page;
        fwd_data <= flag_wr_data;
    end

    assign old_flags = (fwd_en && fwd_page == s2_page) ? fwd_data : flag_rd_data;

    always_comb begin
        upd_flags           = old_flags;
        upd_flags[ACC_USED] = 1'b1;                 // Every translation marks the page used
        if (is_write_op(s2_op)) begin
            upd_flags[ACC_DIRTY] = 1'b1;
        end
        if (s2_valid) begin
            flag_wr_en   = 1'b1;                    // External write dropped this cycle
            flag_wr_page = s2_page;
            flag_wr_data = upd_flags;
        end else begin
            flag_wr_en               = i_flag_wr;
            flag_wr_page             = i_flag_page;
            flag_wr_data[ACC_USED]   = i_flag_used;
            flag_wr_data[ACC_DIRTY]  = i_flag_dirty;
        end
    end

    page_ram #(
        .entry_t   (page_access_t)
    ) u_flag_ram (
        .clk       (clk),
        .i_wr_en   (flag_wr_en),
        .i_wr_page (flag_wr_page),
        .i_wr_data (flag_wr_data),
        .i_rd_page (flag_rd_page),
        .o_rd_data (flag_rd_data)
    );

    assign o_flag_used  = flag_rd_data[ACC_USED];
    assign o_flag_dirty = flag_rd_data[ACC_DIRTY];

    always_ff @(posedge clk) begin
        if (reset) begin
            o_rsp_valid <= 1'b0;
        end else begin
            o_rsp_valid <= s2_valid;                // Two edges after acceptance
        end
        if (s2_valid) begin
            o_rsp_physad <= {s2_page, s2_offset};
            o_rsp_op     <= s2_op;
        end
    end

endmodule

// ==== rtl/mmu_top.sv ====
`timescale 1ns/1ps

module mmu_top
    import mmu_pkg::*;
#(
    parameter int CREDITS = 4                       // Downstream response credits
) (
    input  logic      clk,
    input  logic      reset,

    // Translation requests
    input  logic      i_req_valid,
    input  vaddr_t    i_req_vaddr,
    input  bus_op_t   i_req_op,
    output logic      o_req_ready,

    // Translated responses
    output logic      o_rsp_valid,
    output physad_t   o_rsp_physad,
    output bus_op_t   o_rsp_op,
    input  logic      i_credit_return,              // One credit back per pulse

    // Mode bits
    input  logic      i_mode_besm6,
    input  logic      i_no_paging,

    // Page map write
    input  logic      i_map_wr,
    input  page_num_t i_map_vpage,
    input  page_num_t i_map_frame,

    // Per-page flags
    input  page_num_t i_flag_rd_page,
    output logic      o_flag_used,
    output logic      o_flag_dirty,
    output logic      o_flag_reprio,
    input  logic      i_flag_wr,
    input  page_num_t i_flag_page,
    input  logic      i_flag_used,
    input  logic      i_flag_dirty,
    input  logic      i_flag_reprio,

    // Reprioritize fill
    input  logic      i_fill_start,
    output logic      o_fill_busy
);

    logic credit_avail;                             // Credit pool not empty
    logic req_accept;                               // Handshake on this edge

    // --------------------------------------------------
    // Request handshake
    // --------------------------------------------------
    assign o_req_ready = credit_avail & ~o_fill_busy;
    assign req_accept  = i_req_valid & o_req_ready;

    credit_counter #(
        .CREDITS  (CREDITS)
    ) u_credit (
        .clk      (clk),
        .reset    (reset),
        .i_take   (req_accept),
        .i_return (i_credit_return),
        .o_avail  (credit_avail)
    );

    reprio_fill_fsm u_fill (
        .clk          (clk),
        .reset        (reset),
        .i_fill_start (i_fill_start),
        .i_wr         (i_flag_wr),
        .i_wr_page    (i_flag_page),
        .i_wr_reprio  (i_flag_reprio),
        .i_rd_page    (i_flag_rd_page),
        .o_rd_reprio  (o_flag_reprio),
        .o_busy       (o_fill_busy)
    );

    // --------------------------------------------------
    // Translation pipeline
    // --------------------------------------------------
    page_translate u_translate (
        .clk            (clk),
        .reset          (reset),
        .i_accept       (req_accept),
        .i_vaddr        (i_req_vaddr),
        .i_op           (i_req_op),
        .i_mode_besm6   (i_mode_besm6),
        .i_no_paging    (i_no_paging),
        .i_map_wr       (i_map_wr),
        .i_map_vpage    (i_map_vpage),
        .i_map_frame    (i_map_frame),
        .i_flag_wr      (i_flag_wr),
        .i_flag_page    (i_flag_page),
        .i_flag_used    (i_flag_used),
        .i_flag_dirty   (i_flag_dirty),
        .i_flag_rd_page (i_flag_rd_page),
        .o_flag_used    (o_flag_used),
        .o_flag_dirty   (o_flag_dirty),
        .o_rsp_valid    (o_rsp_valid),
        .o_rsp_physad   (o_rsp_physad),
        .o_rsp_op       (o_rsp_op)
    );

endmodule

// ==== bench/mmu_chk.sv ====
`timescale 1ns/1ps

module mmu_chk #(
    parameter int CREDITS = 4
) (
    input logic clk,
    input logic reset,
    input logic i_req_valid,
    input logic i_req_ready,
    input logic i_credit_return,
    input logic i_fill_busy,
    input logic i_rsp_valid
);

    logic accept;                                   // Handshake seen at the ports
    int   free_cnt;                                 // Credits left, rebuilt from the ports
    int   fail_cnt = 0;                             // Failed assertions so far

    assign accept = i_req_valid && i_req_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            free_cnt <= CREDITS;
        end else begin
            free_cnt <= free_cnt - int'(accept) + int'(i_credit_return);
        end
    end

    // --------------------------------------------------
    // Credit pool
    // --------------------------------------------------
    a_credit_range: assert property (@(posedge clk) disable iff (reset)
        free_cnt >= 0 && free_cnt <= CREDITS)
        else begin
            fail_cnt++;
            $error("credit count %0d outside 0..%0d", free_cnt, CREDITS);
        end

    a_spare_return: assert property (@(posedge clk) disable iff (reset)
        !(i_credit_return && free_cnt == CREDITS))
        else begin
            fail_cnt++;
            $error("credit returned while the pool is full");
        end

    a_busy_blocks: assert property (@(posedge clk) disable iff (reset)
        i_fill_busy |-> !i_req_ready)
        else begin
            fail_cnt++;
            $error("request ready during a reprio fill");
        end

    // --------------------------------------------------
    // Response latency
    // --------------------------------------------------
    // Response register sets on the second edge after acceptance, sampled on the third
    a_rsp_after_accept: assert property (@(posedge clk) disable iff (reset)
        accept |-> ##3 i_rsp_valid)
        else begin
            fail_cnt++;
            $error("no response two cycles after acceptance");
        end

    a_rsp_has_cause: assert property (@(posedge clk) disable iff (reset)
        i_rsp_valid |-> $past(accept, 3))
        else begin
            fail_cnt++;
            $error("response without a matching acceptance");
        end

endmodule

bind mmu_top mmu_chk #(
    .CREDITS         (CREDITS)
) u_chk (
    .clk             (clk),
    .reset           (reset),
    .i_req_valid     (i_req_valid),
    .i_req_ready     (o_req_ready),
    .i_credit_return (i_credit_return),
    .i_fill_busy     (o_fill_busy),
    .i_rsp_valid     (o_rsp_valid)
);

// ==== bench/mmu_tb.sv ====
`timescale 1ns/1ps

module mmu_tb
    import mmu_pkg::*;
();

    localparam int CREDITS     = 4;
    localparam int N_REQ       = 150;               // Requests per translation run
    localparam int CYCLE_LIMIT = 2 * PAGES + 8 * (3 * N_REQ + 100) + 1000; // Tables, fill, runs

    logic        clk = 1'b0;
    logic        reset;
    logic        i_req_valid, i_credit_return, i_mode_besm6, i_no_paging, i_fill_start;
    vaddr_t      i_req_vaddr;
    bus_op_t     i_req_op;
    logic        i_map_wr, i_flag_wr, i_flag_used, i_flag_dirty, i_flag_reprio;
    page_num_t   i_map_vpage, i_map_frame, i_flag_page, i_flag_rd_page;
    logic        o_req_ready, o_rsp_valid, o_flag_used, o_flag_dirty, o_flag_reprio, o_fill_busy;
    physad_t     o_rsp_physad;
    bus_op_t     o_rsp_op;

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    page_num_t   model_map [PAGES];
    logic        model_used [PAGES];
    logic        model_dirty [PAGES];
    logic        model_reprio [PAGES];
    page_num_t   chosen [16];                       // Pages picked by a test
    physad_t     exp_addr_q [$];                    // Expected responses, oldest first
    bus_op_t     exp_op_q [$];
    int          exp_cyc_q [$];                     // Cycle each response is due
    int          ret_q [$];                         // Cycle each credit goes back
    int          model_cnt, fill_left, cycle = 0;
    logic        take_now, give_now, hold_credits, hold_now, armed = 1'b0;
    logic [31:0] stim_seed, delay_seed;
    int          errors = 0, errs_at_start = 0, tests_run = 0, tests_failed = 0;

    mmu_top #(.CREDITS(CREDITS)) uut (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // Command/data cache write, result write, read-modify-write, block write
    function automatic logic writes_memory(input logic [3:0] op);
        return op == 4'd2 || op == 4'd4 || op == 4'd10 || op == 4'd11 || op == 4'd12;
    endfunction

    // Next drive point, strobes back to idle
    task automatic tick();
        @(posedge clk);
        #1;
        i_req_valid  = 1'b0;
        take_now     = 1'b0;
        i_map_wr     = 1'b0;
        i_flag_wr    = 1'b0;
        i_fill_start = 1'b0;
    endtask

    always @(posedge clk) begin
        cycle    <= cycle + 1;
        hold_now <= hold_credits;
        armed    <= !reset;
        if (reset) begin
            model_cnt <= CREDITS;
            fill_left <= 0;
        end else begin
            model_cnt <= model_cnt - int'(take_now) + int'(give_now);
            if (fill_left != 0) begin
                fill_left <= fill_left - 1;
            end else if (i_fill_start) begin
                fill_left <= PAGES;                 // Busy from the next cycle on
            end
        end
        if (cycle == CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // --------------------------------------------------
    // Response monitor and downstream credit returns
    // --------------------------------------------------
    always @(posedge clk) begin
        #1;
        give_now        = 1'b0;
        i_credit_return = 1'b0;
        if (armed) begin
            assert (o_fill_busy === (fill_left != 0)) else begin
                errors++;
                $display("Mismatch at %0t ns: o_fill_busy %b, expected %b", $time, o_fill_busy,
                         fill_left != 0);
            end
            if (o_rsp_valid === 1'b1) begin
                assert (exp_addr_q.size() != 0) else begin
                    errors++;
                    $display("Response at %0t ns arrived with no request outstanding", $time);
                end
                if (exp_addr_q.size() != 0) begin
                    assert (o_rsp_physad === exp_addr_q[0] && o_rsp_op === exp_op_q[0]
                            && cycle == exp_cyc_q[0]) else begin
                        errors++;
                        $display("Mismatch at %0t ns: physad %h op %0d, expected %h op %0d in cycle %0d",
                                 $time, o_rsp_physad, o_rsp_op, exp_addr_q[0], exp_op_q[0],
                                 exp_cyc_q[0]);
                    end
                    void'(exp_addr_q.pop_front());
                    void'(exp_op_q.pop_front());
                    void'(exp_cyc_q.pop_front());
                    delay_seed = xorshift32(delay_seed);
                    ret_q.push_back(cycle + 1 + int'(delay_seed[1:0])); // 1 to 4 cycles later
                end
            end
            if (!hold_now && ret_q.size() != 0 && ret_q[0] <= cycle) begin
                void'(ret_q.pop_front());
                give_now        = 1'b1;
                i_credit_return = 1'b1;
            end
        end
    end

    task automatic drive_request(input logic want, input vaddr_t va, input bus_op_t op,
                                 output logic taken);
        logic      exp_ready;
        page_num_t vp;
        page_num_t pp;
        exp_ready = (model_cnt > 0) && (fill_left == 0);
        taken     = want && exp_ready;
        assert (o_req_ready === exp_ready) else begin
            errors++;
            $display("Mismatch at %0t ns: o_req_ready %b, expected %b", $time, o_req_ready,
                     exp_ready);
        end
        i_req_valid = want;
        i_req_vaddr = va;
        i_req_op    = op;
        take_now    = taken;
        if (taken) begin
            vp = i_mode_besm6 ? page_num_t'(va[14:10]) : va[19:10]; // Five page bits in BESM-6
            pp = i_no_paging ? vp : model_map[vp];
            exp_addr_q.push_back({pp, va[9:0]});
            exp_op_q.push_back(op);
            exp_cyc_q.push_back(cycle + 3);
            model_used[pp] = 1'b1;
            if (writes_memory(op)) begin
                model_dirty[pp] = 1'b1;
            end
        end
    endtask

    // Wait for all responses and all credits back
    task automatic drain();
        while (exp_addr_q.size() != 0 || model_cnt != CREDITS) begin
            tick();
        end
    endtask

    task automatic run_requests(input int n, input logic use_chosen);
        int     sent;
        logic   taken;
        vaddr_t va;
        sent = 0;
        while (sent < n) begin
            stim_seed = xorshift32(stim_seed);
            va = stim_seed[31:12];
            if (use_chosen) begin
                va[19:10] = chosen[stim_seed[6:4]];
            end
            drive_request(stim_seed[1:0] != 2'b00, va, stim_seed[11:8], taken); // 3 in 4 valid
            sent += int'(taken);
            tick();
        end
        drain();
    endtask

    task automatic write_flags(input page_num_t p, input logic used, input logic dirty,
                               input logic reprio);
        i_flag_wr       = 1'b1;
        i_flag_page     = p;
        i_flag_used     = used;
        i_flag_dirty    = dirty;
        i_flag_reprio   = reprio;
        model_used[p]   = used;
        model_dirty[p]  = dirty;
        model_reprio[p] = reprio;
        tick();
    endtask

    task automatic check_flags(input page_num_t p);
        i_flag_rd_page = p;
        tick();
        assert (o_flag_used === model_used[p] && o_flag_dirty === model_dirty[p]
                && o_flag_reprio === model_reprio[p]) else begin
            errors++;
            $display("Mismatch at %0t ns: page %0d used/dirty/reprio %b%b%b, expected %b%b%b",
                     $time, p, o_flag_used, o_flag_dirty, o_flag_reprio, model_used[p],
                     model_dirty[p], model_reprio[p]);
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors != errs_at_start) begin
            tests_failed++;
        end
        $display("Test %-11s %s, %0d errors", name,
                 (errors == errs_at_start) ? "ok" : "failed", errors - errs_at_start);
        errs_at_start = errors;
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        int   taken_cnt;
        int   busy_len;
        logic taken;
        reset           = 1'b1;
        i_req_valid     = 1'b0;
        i_req_vaddr     = '0;
        i_req_op        = '0;
        i_credit_return = 1'b0;
        i_mode_besm6    = 1'b0;
        i_no_paging     = 1'b0;
        i_map_wr        = 1'b0;
        i_map_vpage     = '0;
        i_map_frame     = '0;
        i_flag_wr       = 1'b0;
        i_flag_page     = '0;
        i_flag_used     = 1'b0;
        i_flag_dirty    = 1'b0;
        i_flag_reprio   = 1'b0;
        i_flag_rd_page  = '0;
        i_fill_start    = 1'b0;
        take_now        = 1'b0;
        give_now        = 1'b0;
        hold_credits    = 1'b0;
        stim_seed       = 32'he4d4;
        delay_seed      = ~32'he4d4;                // Separate stream for credit delays
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        for (int i = 0; i < PAGES; i++) begin       // Map and flags of every page known
            stim_seed    = xorshift32(stim_seed);
            i_map_wr     = 1'b1;
            i_map_vpage  = page_num_t'(i);
            i_map_frame  = stim_seed[9:0];
            model_map[i] = stim_seed[9:0];
            write_flags(page_num_t'(i), 1'b0, 1'b0, 1'b0);
        end

        for (int i = 0; i < 32; i++) begin
            stim_seed   = xorshift32(stim_seed);
            i_map_wr    = 1'b1;
            i_map_vpage = stim_seed[19:10];
            i_map_frame = stim_seed[9:0];
            model_map[stim_seed[19:10]] = stim_seed[9:0];
            tick();
        end
        run_requests(N_REQ, 1'b0);
        report_test("translate");

        i_mode_besm6 = 1'b1;
        run_requests(N_REQ, 1'b0);
        i_mode_besm6 = 1'b0;
        i_no_paging  = 1'b1;
        run_requests(N_REQ, 1'b0);
        i_no_paging  = 1'b0;
        report_test("modes");

        hold_credits = 1'b1;                        // Downstream keeps every credit
        taken_cnt    = 0;
        repeat (2 * CREDITS + 6) begin
            stim_seed = xorshift32(stim_seed);
            taken_cnt += int'(o_req_ready === 1'b1);
            drive_request(1'b1, stim_seed[31:12], stim_seed[11:8], taken);
            tick();
        end
        assert (taken_cnt == CREDITS) else begin
            errors++;
            $display("Mismatch at %0t ns: %0d requests taken without returns, expected %0d",
                     $time, taken_cnt, CREDITS);
        end
        hold_credits = 1'b0;
        run_requests(24, 1'b0);
        report_test("credits");

        for (int i = 0; i < 8; i++) begin
            stim_seed = xorshift32(stim_seed);
            chosen[i] = stim_seed[9:0];
            write_flags(model_map[chosen[i]], 1'b0, 1'b0, model_reprio[model_map[chosen[i]]]);
        end
        run_requests(48, 1'b1);
        for (int i = 0; i < 8; i++) begin
            check_flags(model_map[chosen[i]]);
        end
        report_test("used_dirty");

        for (int i = 0; i < 16; i++) begin
            stim_seed = xorshift32(stim_seed);
            chosen[i] = stim_seed[9:0];
            write_flags(chosen[i], model_used[chosen[i]], model_dirty[chosen[i]], 1'b0);
        end
        i_fill_start = 1'b1;
        tick();
        busy_len = 0;
        while (o_fill_busy === 1'b1) begin          // Requests offered and refused throughout
            busy_len++;
            stim_seed = xorshift32(stim_seed);
            drive_request(1'b1, stim_seed[31:12], stim_seed[11:8], taken);
            tick();
        end
        assert (busy_len == PAGES) else begin
            errors++;
            $display("Mismatch at %0t ns: fill busy for %0d cycles, expected %0d", $time,
                     busy_len, PAGES);
        end
        for (int i = 0; i < PAGES; i++) begin
            model_reprio[i] = 1'b1;
        end
        for (int i = 0; i < 16; i++) begin
            check_flags(chosen[i]);
            stim_seed = xorshift32(stim_seed);
            check_flags(stim_seed[9:0]);
        end
        report_test("fill");

        errors += uut.u_chk.fail_cnt;               // Concurrent assertion failures too
        $display("Summary: %0d tests, %0d failed, %0d errors, %0d assertion failures",
                 tests_run, tests_failed, errors, uut.u_chk.fail_cnt);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
rtl/mmu_pkg.sv
rtl/page_ram.sv
rtl/credit_counter.sv
rtl/reprio_fill_fsm.sv
rtl/page_translate.sv
rtl/mmu_top.sv
bench/mmu_chk.sv
bench/mmu_tb.sv
